// File: Makefile
VERILATOR ?= verilator
TOP       ?= permutationCounterTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR) -o V$(TOP)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: build.f
+incdir+verilog
verilog/permTypes.sv
verilog/botInputFifo.sv
verilog/permutationGenerator67.sv
verilog/permuteCheck24.sv
verilog/permutationTally.sv
verilog/permutationCounterTop.sv
test/permutationCounterTb.sv

// File: test/permutationCounterTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "permGlobals_defines.svh"

module permutationCounterTb;

    import permTypes::*;

    typedef logic [`FIFO_DEPTH_LOG2:0] levelT;

    localparam int resultTimeout = 500;
    localparam levelT fifoDepth = levelT'(1 << `FIFO_DEPTH_LOG2);

    logic clk;
    logic rst;
    botT top;
    botT botIn;
    logic botInStrobe;
    levelT usedw;
    tallyT resultCount;
    logic resultStrobe;

    integer seed;
    int errors;
    int checks;
    botT batch [$];

    permutationCounterTop u_dut (
        .clk(clk),
        .rst(rst),
        .top(top),
        .botIn(botIn),
        .botInStrobe(botInStrobe),
        .usedw(usedw),
        .resultCount(resultCount),
        .resultStrobe(resultStrobe)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // the input has no back-pressure, so the level must stay within depth.
    always @(negedge clk) begin
        if (!rst && usedw > fifoDepth) begin
            errors++;
            $display("At %0t usedw reached %0d, above the FIFO depth", $time, usedw);
        end
    end

    task automatic checkCount(tallyT expected, tallyT actual, string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkLevel(levelT expected, levelT actual, string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // truth-table index after exchanging variables a and c.
    function automatic int exchangeBits(int n, int a, int c);
        if (((n >> a) ^ (n >> c)) & 1) begin
            return n ^ ((1 << a) | (1 << c));
        end
        return n;
    endfunction

    // variable 3+k of n moves to variable 3+o[k].
    function automatic int reorderUpper(int n, int o0, int o1, int o2, int o3);
        int m;
        m = n & 7;
        m |= ((n >> 3) & 1) << (3 + o0);
        m |= ((n >> 4) & 1) << (3 + o1);
        m |= ((n >> 5) & 1) << (3 + o2);
        m |= ((n >> 6) & 1) << (3 + o3);
        return m;
    endfunction

    // reference count over 42 swap pairs and all 24 orderings of variables 3..6.
    function automatic tallyT countBelowTop(botT bot, botT topFn);
        int total;
        int m;
        bit below;
        total = 0;
        for (int i = 0; i < 7; i++) begin
            for (int j = 1; j < 7; j++) begin
                for (int a = 0; a < 4; a++) begin
                    for (int b = 0; b < 4; b++) begin
                        for (int c = 0; c < 4; c++) begin
                            if (a != b && a != c && b != c) begin
                                below = 1'b1;
                                for (int n = 0; n < `BOT_WIDTH; n++) begin
                                    if (bot[n]) begin
                                        m = exchangeBits(exchangeBits(n, 0, i), 1, j);
                                        m = reorderUpper(m, a, b, c, 6 - a - b - c);
                                        if (!topFn[m]) below = 1'b0;
                                    end
                                end
                                if (below) total++;
                            end
                        end
                    end
                end
            end
        end
        return tallyT'(total);
    endfunction

    function automatic botT randomBot();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // few minterms, so some permutations fit under a dense top.
    function automatic botT sparseBot();
        return randomBot() & randomBot() & randomBot();
    endfunction

    function automatic botT denseTop();
        return randomBot() | randomBot() | randomBot();
    endfunction

    task automatic sendBot(botT b);
        botIn = b;
        botInStrobe = 1'b1;
        @(negedge clk);
        botInStrobe = 1'b0;
    endtask

    task automatic collect(tallyT expected, string label);
        int cycles;
        bit seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < resultTimeout) begin
            @(negedge clk);
            cycles++;
            if (resultStrobe) begin
                seen = 1'b1;
                checkCount(expected, resultCount, "resultCount");
            end
        end
        if (!seen) begin
            errors++;
            $display("At %0t no resultStrobe arrived for the %s test", $time, label);
        end
    endtask

    // back-to-back strobes, then results in input order.
    task automatic runBatch(string label);
        tallyT expected [$];
        expected = {};
        foreach (batch[k]) expected.push_back(countBelowTop(batch[k], top));
        foreach (batch[k]) sendBot(batch[k]);
        foreach (expected[k]) collect(expected[k], label);
        batch = {};
    endtask

    task automatic testConstantBots();
        top = randomBot();
        sendBot('0);
        collect(tallyT'(1008), "all-zero bot");
        sendBot('1);
        collect(tallyT'(0), "all-ones bot");
        top = '1;
        sendBot('1);
        collect(tallyT'(1008), "all-ones top");
    endtask

    task automatic testSingleMinterms();
        int minterms [8] = '{0, 3, 6, 7, 56, 65, 96, 127};
        top = '0;
        top[3] = 1'b1;
        top[10] = 1'b1;
        top[80] = 1'b1;
        top[7] = 1'b1;
        top[127] = 1'b1;
        foreach (minterms[k]) batch.push_back(botT'(1) << minterms[k]);
        runBatch("single-minterm");
    endtask

    task automatic testRandomBots();
        top = denseTop();
        for (int g = 0; g < 5; g++) begin
            for (int k = 0; k < 4; k++) batch.push_back(sparseBot());
            runBatch("random");
        end
    endtask

    task automatic testBurst();
        tallyT expected [$];
        expected = {};
        top = denseTop();
        for (int k = 0; k < 12; k++) batch.push_back(sparseBot());
        foreach (batch[k]) expected.push_back(countBelowTop(batch[k], top));
        foreach (batch[k]) sendBot(batch[k]);
        // the first pop is immediate and a second needs a generator wrap.
        checks++;
        if (usedw < levelT'(10) || usedw > levelT'(11)) begin
            errors++;
            $display("Mismatch at %0t: usedw expected 10 or 11, got %0d", $time, usedw);
        end
        foreach (expected[k]) collect(expected[k], "burst");
        batch = {};
        checkLevel('0, usedw, "usedw");
    endtask

    task automatic testResetMidSeries();
        int cycles;
        int stray;
        top = denseTop();
        sendBot(sparseBot());
        cycles = 0;
        while (!u_dut.genBotValid && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (!u_dut.genBotValid) begin
            errors++;
            $display("At %0t the generator never started a series", $time);
        end
        repeat (20) @(negedge clk);
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        checkLevel('0, usedw, "usedw");
        stray = 0;
        for (cycles = 0; cycles < 200; cycles++) begin
            @(negedge clk);
            if (resultStrobe) stray++;
        end
        if (stray != 0) begin
            errors++;
            $display("At %0t resultStrobe pulsed %0d times after reset", $time, stray);
        end
        batch.push_back(sparseBot());
        runBatch("post-reset");
    endtask

    initial begin
        seed = 32'h8ec0;
        errors = 0;
        checks = 0;
        rst = 1'b1;
        top = '0;
        botIn = '0;
        botInStrobe = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        checkLevel('0, usedw, "usedw");
        testConstantBots();
        testSingleMinterms();
        testRandomBots();
        testBurst();
        testResetMidSeries();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/botInputFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "permGlobals_defines.svh"

module botInputFifo #(
    parameter int depthLog2 = `FIFO_DEPTH_LOG2
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire permTypes::botT  botIn,
    input  wire logic            botInStrobe,
    input  wire logic            hasSpaceForNextBot,
    output logic                 writeInputBot,
    output permTypes::botT       fifoBot,
    output logic [depthLog2:0]   usedw
);

    import permTypes::*;

    localparam int depth = 1 << depthLog2;
    localparam logic [depthLog2:0] fullLevel = {1'b1, {depthLog2{1'b0}}};

    botT mem [depth];
    logic [depthLog2-1:0] wrPtr;
    logic [depthLog2-1:0] rdPtr;
    logic [depthLog2:0] count;
    logic full;
    logic empty;
    logic doWrite;
    logic doRead;

    assign empty = (count == '0);
    assign full = (count == fullLevel);

    // pop as soon as the generator slot is free.
    assign doRead = hasSpaceForNextBot && !empty;
    // a pop in the same cycle frees the entry.
    assign doWrite = botInStrobe && (!full || doRead);

    assign writeInputBot = doRead;
    assign fifoBot = mem[rdPtr];
    assign usedw = count;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= botIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // no back-pressure on the input, so a full FIFO must be draining.
    assert property (@(posedge clk) disable iff (rst)
        botInStrobe && full |-> writeInputBot);

endmodule

`default_nettype wire

// File: verilog/permGlobals_defines.svh
`ifndef PERM_GLOBALS_DEFINES_SVH
`define PERM_GLOBALS_DEFINES_SVH

// truth table of a seven-variable function.
`define BOT_WIDTH 128

// function variables.
`define NUM_VARS 7

// orderings of variables 3 to 6.
`define NUM_CHECK_PERMS 24

// holds counts up to 42 * 24 = 1008.
`define TALLY_WIDTH 10

// input FIFO holds 16 bots.
`define FIFO_DEPTH_LOG2 4

`endif

// File: verilog/permTypes.sv
`default_nettype none

`include "permGlobals_defines.svh"

package permTypes;

    typedef logic [`BOT_WIDTH-1:0] botT;
    typedef logic [`NUM_CHECK_PERMS-1:0] permMaskT;
    typedef logic [`TALLY_WIDTH-1:0] tallyT;

    // exchange variables a and c, bit n moves to n with bits a and c swapped.
    function automatic botT varSwap(botT b, int a, int c);
        botT result;
        int n;
        int m;
        int bitA;
        int bitC;
        for (n = 0; n < `BOT_WIDTH; n++) begin
            bitA = (n >> a) & 1;
            bitC = (n >> c) & 1;
            m = n & ~((1 << a) | (1 << c));
            m = m | (bitA << c) | (bitC << a);
            result[m] = b[n];
        end
        return result;
    endfunction

    // ordering p of variables 3..6, lexicographic, p = 0 is the identity.
    function automatic botT permuteUpper4(botT b, int p);
        int pool [4];
        int order [4];
        int rem;
        int radix;
        int pick;
        int k;
        int j;
        int n;
        int m;
        botT result;
        for (k = 0; k < 4; k++) begin
            pool[k] = k;
        end
        rem = p;
        radix = 6;
        // factorial digits pick from the remaining variables.
        for (k = 0; k < 4; k++) begin
            pick = rem / radix;
            rem = rem % radix;
            order[k] = pool[pick];
            for (j = 0; j < 3; j++) begin
                if (j >= pick) begin
                    pool[j] = pool[j + 1];
                end
            end
            radix = (radix > 1) ? radix / (3 - k) : 1;
        end
        for (n = 0; n < `BOT_WIDTH; n++) begin
            m = n & 7;
            for (k = 0; k < 4; k++) begin
                m = m | (((n >> (3 + k)) & 1) << (3 + order[k]));
            end
            result[m] = b[n];
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: verilog/permutationCounterTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "permGlobals_defines.svh"

module permutationCounterTop (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire permTypes::botT         top,
    input  wire permTypes::botT         botIn,
    input  wire logic                   botInStrobe,
    output logic [`FIFO_DEPTH_LOG2:0]   usedw,
    output permTypes::tallyT            resultCount,
    output logic                        resultStrobe
);

    import permTypes::*;

    botT fifoBot;
    logic writeInputBot;
    logic hasSpaceForNextBot;

    botT genBot;
    logic genBotValid;
    logic genSeriesFinished;

    permMaskT validMask;
    logic maskValid;
    logic seriesDone;

    botInputFifo #(
        .depthLog2(`FIFO_DEPTH_LOG2)
    ) inputFifo (
        .clk(clk),
        .rst(rst),
        .botIn(botIn),
        .botInStrobe(botInStrobe),
        .hasSpaceForNextBot(hasSpaceForNextBot),
        .writeInputBot(writeInputBot),
        .fifoBot(fifoBot),
        .usedw(usedw)
    );

    permutationGenerator67 generator (
        .clk(clk),
        .rst(rst),
        .inputBot(fifoBot),
        .writeInputBot(writeInputBot),
        .hasSpaceForNextBot(hasSpaceForNextBot),
        .outputBot(genBot),
        .outputBotValid(genBotValid),
        .botSeriesFinished(genSeriesFinished)
    );

    permuteCheck24 permCheck (
        .clk(clk),
        .rst(rst),
        .top(top),
        .bot(genBot),
        .botValid(genBotValid),
        .seriesIn(genSeriesFinished),
        .validMask(validMask),
        .maskValid(maskValid),
        .seriesOut(seriesDone)
    );

    permutationTally tally (
        .clk(clk),
        .rst(rst),
        .validMask(validMask),
        .maskValid(maskValid),
        .seriesDone(seriesDone),
        .resultCount(resultCount),
        .resultStrobe(resultStrobe)
    );

endmodule

`default_nettype wire

// File: verilog/permutationGenerator67.sv
`timescale 1ns/1ps
`default_nettype none

`include "permGlobals_defines.svh"

module permutationGenerator67 (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire permTypes::botT inputBot,
    input  wire logic           writeInputBot,
    output logic                hasSpaceForNextBot,
    output permTypes::botT      outputBot,
    output logic                outputBotValid,
    output logic                botSeriesFinished
);

    import permTypes::*;

    localparam logic [2:0] innerLast = 3'(`NUM_VARS - 1);
    localparam logic [2:0] outerLast = 3'(`NUM_VARS - 2);

    botT nextBot;
    logic nextBotValid;
    botT currentlyPermuting;
    logic currentlyPermutingValid;

    logic [2:0] innerCount;
    logic [2:0] outerCount;
    logic wrap;

    botT firstStage [`NUM_VARS];
    botT selectedFirst;
    botT secondStage [`NUM_VARS-1];

    assign hasSpaceForNextBot = !nextBotValid;
    // last of the 42 swap pairs.
    assign wrap = (innerCount == innerLast) && (outerCount == outerLast);

    // pending slot.
    always_ff @(posedge clk) begin
        if (rst) begin
            nextBotValid <= 1'b0;
        end else if (writeInputBot) begin
            nextBotValid <= 1'b1;
        end else if (wrap) begin
            nextBotValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (writeInputBot) begin
            nextBot <= inputBot;
        end
        if (wrap) begin
            currentlyPermuting <= nextBot;
        end
    end

    // free-running 7 x 6 sequencer.
    always_ff @(posedge clk) begin
        if (rst) begin
            innerCount <= '0;
            outerCount <= '0;
            currentlyPermutingValid <= 1'b0;
            botSeriesFinished <= 1'b0;
        end else begin
            botSeriesFinished <= 1'b0;
            if (innerCount == innerLast) begin
                innerCount <= '0;
                if (outerCount == outerLast) begin
                    outerCount <= '0;
                    currentlyPermutingValid <= nextBotValid;
                    botSeriesFinished <= currentlyPermutingValid;
                end else begin
                    outerCount <= outerCount + 1'b1;
                end
            end else begin
                innerCount <= innerCount + 1'b1;
            end
        end
    end

    // swap variable 0 with i, then variable 1 with j+1.
    for (genvar i = 0; i < `NUM_VARS; i++) begin : genFirst
        assign firstStage[i] = varSwap(currentlyPermuting, 0, i);
    end

    assign selectedFirst = firstStage[innerCount];

    for (genvar j = 0; j < `NUM_VARS - 1; j++) begin : genSecond
        assign secondStage[j] = varSwap(selectedFirst, 1, j + 1);
    end

    assign outputBot = secondStage[outerCount];
    assign outputBotValid = currentlyPermutingValid;

    // the FIFO only pops into an empty slot.
    assert property (@(posedge clk) disable iff (rst)
        writeInputBot |-> !nextBotValid);

endmodule

`default_nettype wire

// File: verilog/permutationTally.sv
`timescale 1ns/1ps
`default_nettype none

`include "permGlobals_defines.svh"

module permutationTally (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire permTypes::permMaskT validMask,
    input  wire logic               maskValid,
    input  wire logic               seriesDone,
    output permTypes::tallyT        resultCount,
    output logic                    resultStrobe
);

    import permTypes::*;

    // 42 generator pairs times 24 orderings.
    localparam int maxTally = `NUM_VARS * (`NUM_VARS - 1) * `NUM_CHECK_PERMS;

    tallyT runningSum;
    tallyT maskCount;

    function automatic tallyT popCount(permMaskT mask);
        tallyT total;
        int k;
        total = '0;
        for (k = 0; k < `NUM_CHECK_PERMS; k++) begin
            total = total + tallyT'(mask[k]);
        end
        return total;
    endfunction

    assign maskCount = popCount(validMask);

    always_ff @(posedge clk) begin
        if (rst) begin
            runningSum <= '0;
            resultStrobe <= 1'b0;
        end else begin
            resultStrobe <= seriesDone;
            if (seriesDone) begin
                // next series may already have its first mask here.
                runningSum <= maskValid ? maskCount : '0;
            end else if (maskValid) begin
                runningSum <= runningSum + maskCount;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (seriesDone) begin
            resultCount <= runningSum;
        end
    end

    // one series never sees more than 42 masks.
    assert property (@(posedge clk) disable iff (rst)
        runningSum <= tallyT'(maxTally));

endmodule

`default_nettype wire

// File: verilog/permuteCheck24.sv
`timescale 1ns/1ps
`default_nettype none

`include "permGlobals_defines.svh"

module permuteCheck24 (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire permTypes::botT top,
    input  wire permTypes::botT bot,
    input  wire logic           botValid,
    input  wire logic           seriesIn,
    output permTypes::permMaskT validMask,
    output logic                maskValid,
    output logic                seriesOut
);

    import permTypes::*;

    botT permuted [`NUM_CHECK_PERMS];
    permMaskT maskNext;

    // one subset test per ordering of variables 3..6.
    for (genvar p = 0; p < `NUM_CHECK_PERMS; p++) begin : genCheck
        assign permuted[p] = permuteUpper4(bot, p);
        // below top: no 1 where top has a 0.
        assign maskNext[p] = ~|(permuted[p] & ~top);
    end

    always_ff @(posedge clk) begin
        validMask <= maskNext;
    end

    // flags stay aligned with the mask.
    always_ff @(posedge clk) begin
        if (rst) begin
            maskValid <= 1'b0;
            seriesOut <= 1'b0;
        end else begin
            maskValid <= botValid;
            seriesOut <= seriesIn;
        end
    end

endmodule

`default_nettype wire
